//--- hw/riscv_pipe_params.svh
`ifndef RISCV_PIPE_PARAMS_SVH
`define RISCV_PIPE_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address after reset
`define PC_RESET 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

//--- hw/riscv_pipe_pkg.sv
`default_nettype none

`include "riscv_pipe_params.svh"

package riscv_pipe_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_t;

    // operand source in decode
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EXE  = 2'd1,
        FWD_MEM  = 2'd2,
        FWD_WB   = 2'd3
    } fwd_sel_t;

    typedef enum logic {
        WB_EXE = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_t;

endpackage

`default_nettype wire

//--- hw/riscv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_decoder
    import riscv_pipe_pkg::*;
(
    input  word_t     instr,
    output alu_op_t   alu_op,
    output word_t     imm,
    output logic      use_imm,
    output logic      zero_a,
    output logic      reg_write,
    output logic      mem_read,
    output logic      mem_write,
    output logic      is_branch,
    output logic      branch_ne,
    output logic      is_jump,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output reg_addr_t rd,
    output reg_addr_t rs1,
    output reg_addr_t rs2
);

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        zero_a    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jump   = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    // shifts and slt are not implemented
                    default: reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                uses_rs1  = 1'b1;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            OPC_LUI: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                zero_a    = 1'b1;
                reg_write = 1'b1;
            end
            OPC_LOAD: begin
                // word access only
                uses_rs1  = 1'b1;
                use_imm   = 1'b1;
                reg_write = (funct3 == 3'b010);
                mem_read  = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                imm       = imm_s;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                use_imm   = 1'b1;
                mem_write = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                imm       = imm_b;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                branch_ne = (funct3 == 3'b001);
            end
            OPC_JAL: begin
                imm       = imm_j;
                reg_write = 1'b1;
                is_jump   = 1'b1;
            end
            default: begin
                // anything else runs as a nop
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/riscv_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_hazard_unit
    import riscv_pipe_pkg::*;
(
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  logic      id_uses_rs1,
    input  logic      id_uses_rs2,
    input  logic      id_use_imm,
    input  reg_addr_t ex_rd,
    input  logic      ex_reg_write,
    input  logic      ex_mem_read,
    input  reg_addr_t mem_rd,
    input  logic      mem_reg_write,
    input  reg_addr_t wb_rd,
    input  logic      wb_reg_write,
    input  logic      branch_taken,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output fwd_sel_t  fwd_rs2,
    output logic      stall,
    output logic      kill
);

    logic load_use;

    // youngest producer wins and x0 is never forwarded
    function automatic fwd_sel_t pick(input reg_addr_t rs, input logic used,
                                      input reg_addr_t e_rd, input logic e_wr,
                                      input reg_addr_t m_rd, input logic m_wr,
                                      input reg_addr_t w_rd, input logic w_wr);
        if (!used || rs == '0) begin
            pick = FWD_NONE;
        end else if (e_wr && e_rd == rs) begin
            pick = FWD_EXE;
        end else if (m_wr && m_rd == rs) begin
            pick = FWD_MEM;
        end else if (w_wr && w_rd == rs) begin
            pick = FWD_WB;
        end else begin
            pick = FWD_NONE;
        end
    endfunction

    always_comb begin
        fwd_a   = pick(id_rs1, id_uses_rs1, ex_rd, ex_reg_write,
                       mem_rd, mem_reg_write, wb_rd, wb_reg_write);
        fwd_b   = pick(id_rs2, id_uses_rs2 && !id_use_imm, ex_rd, ex_reg_write,
                       mem_rd, mem_reg_write, wb_rd, wb_reg_write);
        fwd_rs2 = pick(id_rs2, id_uses_rs2, ex_rd, ex_reg_write,
                       mem_rd, mem_reg_write, wb_rd, wb_reg_write);

        // load data only exists one stage later
        load_use = ex_mem_read && ex_rd != '0 &&
                   ((id_uses_rs1 && id_rs1 == ex_rd) || (id_uses_rs2 && id_rs2 == ex_rd));
        kill     = branch_taken;
        stall    = load_use && !branch_taken;
    end

endmodule

`default_nettype wire

//--- hw/riscv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_pipe_params.svh"

module riscv_regfile
    import riscv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_addr,
    input  reg_addr_t dbg_addr,
    input  word_t     rd_data,
    input  logic      write_en,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     dbg_data
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[reg_addr_t'(i)] <= '0;
            end
        end else if (write_en && rd_addr != '0) begin
            // x0 is never written, so it stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    // combinational reads see a same-cycle write only through forwarding
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

//--- hw/riscv_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_pipe_params.svh"

module riscv_execute
    import riscv_pipe_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   rs2_val,
    input  word_t   pc_val,
    input  word_t   imm,
    input  logic    is_branch,
    input  logic    branch_ne,
    input  logic    is_jump,
    output word_t   result,
    output word_t   target,
    output logic    branch_taken
);

    word_t alu_out;
    word_t link;
    logic  equal;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            default: alu_out = op_a + op_b;
        endcase
    end

    // return address for jal
    assign link   = pc_val + `XLEN'(4);
    assign result = is_jump ? link : alu_out;

    // branch and jal share one target adder
    assign target = pc_val + imm;

    // beq and bne compare rs1 with the rs2 value, not the alu operand
    assign equal        = (op_a == rs2_val);
    assign branch_taken = is_jump || (is_branch && (branch_ne ? !equal : equal));

endmodule

`default_nettype wire

//--- hw/riscv_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_pipe_params.svh"

module riscv_pipe
    import riscv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output word_t     pc,
    input  word_t     instruction,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      mem_read_en,
    output logic      mem_write_en,
    input  word_t     mem_rdata,
    input  reg_addr_t reg_dbg_addr,
    output word_t     reg_dbg_data
);

    // fetch/decode
    word_t     id_instr;
    word_t     id_pc;
    // decoder outputs
    alu_op_t   id_alu_op;
    word_t     id_imm;
    logic      id_use_imm;
    logic      id_zero_a;
    logic      id_reg_write;
    logic      id_mem_read;
    logic      id_mem_write;
    logic      id_is_branch;
    logic      id_branch_ne;
    logic      id_is_jump;
    logic      id_uses_rs1;
    logic      id_uses_rs2;
    reg_addr_t id_rd;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    word_t     rf_rs1;
    word_t     rf_rs2;
    word_t     id_op_a;
    word_t     id_op_b;
    word_t     id_rs2_val;
    // decode/execute
    alu_op_t   ex_alu_op;
    logic      ex_reg_write;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_is_branch;
    logic      ex_branch_ne;
    logic      ex_is_jump;
    reg_addr_t ex_rd;
    word_t     ex_op_a;
    word_t     ex_op_b;
    word_t     ex_rs2_val;
    word_t     ex_pc;
    word_t     ex_imm;
    word_t     ex_result;
    word_t     ex_target;
    logic      branch_taken;
    // execute/memory
    logic      mem_reg_write;
    logic      mem_mem_read;
    logic      mem_mem_write;
    reg_addr_t mem_rd;
    word_t     mem_result;
    word_t     mem_store_data;
    wb_sel_t   mem_wb_sel;
    word_t     mem_wb_data;
    // memory/writeback
    logic      wb_reg_write;
    reg_addr_t wb_rd;
    word_t     wb_data;
    // hazard control
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    fwd_sel_t  fwd_rs2;
    logic      stall;
    logic      kill;

    function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t base,
                                       input word_t from_exe, input word_t from_mem,
                                       input word_t from_wb);
        case (sel)
            FWD_EXE: fwd_pick = from_exe;
            FWD_MEM: fwd_pick = from_mem;
            FWD_WB:  fwd_pick = from_wb;
            default: fwd_pick = base;
        endcase
    endfunction

    // pc and fetch/decode, a taken branch in execute redirects fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `PC_RESET;
            id_instr <= `NOP_INSTR;
        end else if (kill) begin
            pc       <= ex_target;
            id_instr <= `NOP_INSTR;
        end else if (!stall) begin
            pc       <= pc + `XLEN'(4);
            id_instr <= instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    riscv_decoder u_riscv_decoder (
        .instr     (id_instr),
        .alu_op    (id_alu_op),
        .imm       (id_imm),
        .use_imm   (id_use_imm),
        .zero_a    (id_zero_a),
        .reg_write (id_reg_write),
        .mem_read  (id_mem_read),
        .mem_write (id_mem_write),
        .is_branch (id_is_branch),
        .branch_ne (id_branch_ne),
        .is_jump   (id_is_jump),
        .uses_rs1  (id_uses_rs1),
        .uses_rs2  (id_uses_rs2),
        .rd        (id_rd),
        .rs1       (id_rs1),
        .rs2       (id_rs2)
    );

    riscv_regfile u_riscv_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (id_rs1),
        .rs2_addr (id_rs2),
        .rd_addr  (wb_rd),
        .dbg_addr (reg_dbg_addr),
        .rd_data  (wb_data),
        .write_en (wb_reg_write),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .dbg_data (reg_dbg_data)
    );

    riscv_hazard_unit u_riscv_hazard_unit (
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_uses_rs1   (id_uses_rs1),
        .id_uses_rs2   (id_uses_rs2),
        .id_use_imm    (id_use_imm),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write),
        .branch_taken  (branch_taken),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fwd_rs2       (fwd_rs2),
        .stall         (stall),
        .kill          (kill)
    );

    // forwarding muxes in decode
    always_comb begin
        id_op_a    = fwd_pick(fwd_a, id_zero_a ? '0 : rf_rs1,
                              ex_result, mem_wb_data, wb_data);
        id_op_b    = fwd_pick(fwd_b, id_use_imm ? id_imm : rf_rs2,
                              ex_result, mem_wb_data, wb_data);
        id_rs2_val = fwd_pick(fwd_rs2, rf_rs2, ex_result, mem_wb_data, wb_data);
    end

    // decode/execute, bubble on stall or kill
    always_ff @(posedge clk) begin
        if (!rst_n || stall || kill) begin
            ex_alu_op    <= ALU_ADD;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_branch_ne <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_rd        <= '0;
        end else begin
            ex_alu_op    <= id_alu_op;
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_is_branch <= id_is_branch;
            ex_branch_ne <= id_branch_ne;
            ex_is_jump   <= id_is_jump;
            ex_rd        <= id_rd;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_a    <= id_op_a;
        ex_op_b    <= id_op_b;
        ex_rs2_val <= id_rs2_val;
        ex_pc      <= id_pc;
        ex_imm     <= id_imm;
    end

    riscv_execute u_riscv_execute (
        .alu_op       (ex_alu_op),
        .op_a         (ex_op_a),
        .op_b         (ex_op_b),
        .rs2_val      (ex_rs2_val),
        .pc_val       (ex_pc),
        .imm          (ex_imm),
        .is_branch    (ex_is_branch),
        .branch_ne    (ex_branch_ne),
        .is_jump      (ex_is_jump),
        .result       (ex_result),
        .target       (ex_target),
        .branch_taken (branch_taken)
    );

    // execute/memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_rd        <= '0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_rd        <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= ex_result;
        mem_store_data <= ex_rs2_val;
    end

    assign mem_addr     = mem_result;
    assign mem_wdata    = mem_store_data;
    assign mem_read_en  = mem_mem_read;
    assign mem_write_en = mem_mem_write;

    // loads take the ram data, everything else the execute result
    assign mem_wb_sel  = mem_mem_read ? WB_MEM : WB_EXE;
    assign mem_wb_data = (mem_wb_sel == WB_MEM) ? mem_rdata : mem_result;

    // memory/writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
        end else begin
            wb_reg_write <= mem_reg_write;
            wb_rd        <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= mem_wb_data;
    end

    // ram port sees at most one access per cycle
    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read_en && mem_write_en));

endmodule

`default_nettype wire

//--- dv/riscv_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_pipe_params.svh"

module riscv_pipe_tb
    import riscv_pipe_pkg::*;
();

    localparam int ROM_WORDS    = 64;
    localparam int RAM_WORDS    = 256;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 6;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    word_t     instruction;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_read_en;
    logic      mem_write_en;
    word_t     mem_rdata;
    reg_addr_t reg_dbg_addr;
    word_t     reg_dbg_data;

    word_t rom [ROM_WORDS];
    word_t ram [RAM_WORDS];
    int    rom_len;

    // per-test first indices with a closing sentinel in each queue
    string     test_names [$];
    int        prog_first [$];
    int        reg_first [$];
    int        mem_first [$];
    word_t     prog_words [$];
    reg_addr_t exp_reg_idx [$];
    word_t     exp_reg_val [$];
    word_t     exp_mem_addr [$];
    word_t     exp_mem_val [$];

    int error_count = 0;
    int fail_tests  = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    riscv_pipe u_riscv_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .instruction  (instruction),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_read_en  (mem_read_en),
        .mem_write_en (mem_write_en),
        .mem_rdata    (mem_rdata),
        .reg_dbg_addr (reg_dbg_addr),
        .reg_dbg_data (reg_dbg_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // fill value of a ram word that is unique per word index
    function automatic word_t fill_word(input int idx);
        fill_word = 32'hC0DE_0000 | word_t'(idx);
    endfunction

    // nop past the end of the program
    assign instruction = (pc < word_t'(rom_len * 4)) ? rom[pc[7:2]] : `NOP_INSTR;
    // read data is only valid while the read enable is high
    assign mem_rdata   = mem_read_en ? ram[mem_addr[9:2]] : '1;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i[7:0]] <= fill_word(i);
            end
        end else if (mem_write_en) begin
            ram[mem_addr[9:2]] <= mem_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, a program never reached its last word",
                     cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_reg(input string name, input reg_addr_t idx,
                             input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: x%0d expected %h actual %h", name, idx, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_mem(input string name, input word_t addr,
                             input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: mem[%h] expected %h actual %h",
                     name, addr, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    code;
        int    idx;
        string tok;
        string line;
        word_t a;
        word_t w;
        fd = $fopen("dv/riscv_pipe_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/riscv_pipe_tests.txt");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s", tok);
                test_names.push_back(tok);
                prog_first.push_back(prog_words.size());
                reg_first.push_back(exp_reg_idx.size());
                mem_first.push_back(exp_mem_addr.size());
            end else if (tok == "reg") begin
                code = $fscanf(fd, "%d %h", idx, w);
                exp_reg_idx.push_back(reg_addr_t'(idx));
                exp_reg_val.push_back(w);
            end else if (tok == "mem") begin
                code = $fscanf(fd, "%h %h", a, w);
                exp_mem_addr.push_back(a);
                exp_mem_val.push_back(w);
            end else if (tok == "end") begin
                // the next record starts at a test token
            end else if ($sscanf(tok, "%h", w) == 1) begin
                prog_words.push_back(w);
            end else begin
                $display("unknown token %s in the test file", tok);
                error_count++;
            end
        end
        $fclose(fd);
        prog_first.push_back(prog_words.size());
        reg_first.push_back(exp_reg_idx.size());
        mem_first.push_back(exp_mem_addr.size());
    endtask

    task automatic run_test(input int t);
        string name;
        int    errors_before;
        int    n_prog;
        int    cycles;
        word_t end_pc;
        word_t addr;
        name          = test_names[t];
        errors_before = error_count;
        n_prog        = prog_first[t + 1] - prog_first[t];
        end_pc        = word_t'((n_prog - 1) * 4);

        // new program goes in while the previous one spins in its last jal
        @(negedge clk);
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i[5:0]] = (i < n_prog) ? prog_words[prog_first[t] + i] : `NOP_INSTR;
        end
        rom_len = n_prog;
        rst_n   = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (mem_write_en !== 1'b0 || mem_read_en !== 1'b0) begin
                $display("%s: a memory enable is high during reset", name);
                error_count++;
            end
        end
        rst_n = 1'b1;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles <= 2 && mem_write_en !== 1'b0) begin
                $display("%s: memory write enable is high before any store got there", name);
                error_count++;
            end
            // a first store can write at the next edge at the earliest
            if (cycles == 3) begin
                for (int i = 0; i < RAM_WORDS; i++) begin
                    check_mem(name, word_t'(i * 4), fill_word(i), ram[i[7:0]]);
                end
            end
        end while (pc !== end_pc);
        repeat (DRAIN_CYCLES) @(negedge clk);

        for (int k = reg_first[t]; k < reg_first[t + 1]; k++) begin
            reg_dbg_addr = exp_reg_idx[k];
            @(negedge clk);
            check_reg(name, exp_reg_idx[k], exp_reg_val[k], reg_dbg_data);
        end
        for (int k = mem_first[t]; k < mem_first[t + 1]; k++) begin
            addr = exp_mem_addr[k];
            check_mem(name, addr, exp_mem_val[k], ram[addr[9:2]]);
        end

        if (error_count == errors_before) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, error_count - errors_before);
            fail_tests++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        reg_dbg_addr = '0;
        rom_len      = 0;
        load_tests();
        if (test_names.size() == 0) begin
            $display("no tests were read from the test file");
            error_count++;
        end
        for (int t = 0; t < test_names.size(); t++) begin
            cycle_limit += (prog_first[t + 1] - prog_first[t]) * 4 + 30;
        end
        for (int t = 0; t < test_names.size(); t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, errors %0d",
                 test_names.size(), fail_tests, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- riscv_pipe.f
+incdir+hw
hw/riscv_pipe_pkg.sv
hw/riscv_decoder.sv
hw/riscv_hazard_unit.sv
hw/riscv_regfile.sv
hw/riscv_execute.sv
hw/riscv_pipe.sv
dv/riscv_pipe_tb.sv

//--- run.sh
#!/bin/sh
# build the riscv_pipe testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f riscv_pipe.f --top-module riscv_pipe_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

output=$(./obj_dir/Vriscv_pipe_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- dv/riscv_pipe_tests.txt
# records: test <name>, program words in hex, expected values, then end
# reg <index, decimal> <value, hex>    mem <byte address, hex> <value, hex>

# dependent alu ops, forwarded from execute, memory and writeback
test arith
00500093 03A08113 002081B3 40308233 002272B3 0032E333 004343B3
12345437 67846493 0FF4F513 FFF54593 00158633 0000006F
reg 0 00000000  reg 1 00000005  reg 2 0000003F  reg 3 00000044
reg 4 FFFFFFC1  reg 5 00000001  reg 6 00000045  reg 7 FFFFFF84
reg 8 12345000  reg 9 12345678  reg 10 00000078  reg 11 FFFFFF87
reg 12 FFFFFF8C
end

# store then load back, each load feeds the next instruction
test load_store
04000093 CAFE1137 0BE14113 0020A423 0080A183 00318233 01402283
0050A623 0000006F
reg 1 00000040  reg 2 CAFE10BE  reg 3 CAFE10BE  reg 4 95FC217C
reg 5 C0DE0005
mem 48 CAFE10BE  mem 4C C0DE0005  mem 50 C0DE0014
end

# beq and bne, taken and not taken
test branches
00300093 00300113 00208663 00100193 00100213 00209663 00700293
00509463 00100313 00508463 00900393 0000006F
reg 1 00000003  reg 2 00000003  reg 3 00000000  reg 4 00000000
reg 5 00000007  reg 6 00000000  reg 7 00000009
end

test jal
00100093 00C0016F 00100193 00100213 001102B3 0080036F 00100393
0000006F
reg 1 00000001  reg 2 00000008  reg 3 00000000  reg 4 00000000
reg 5 00000009  reg 6 00000018  reg 7 00000000
end

# x0 as destination and as source
test x0_writes
00500013 000000B3 ABCDE037 12300113 06002023 06002183 0000006F
reg 0 00000000  reg 1 00000000  reg 2 00000123  reg 3 00000000
mem 60 00000000  mem 64 C0DE0019
end
